/* flist.f */
verilog/idu_pkg.sv
verilog/control_unit.sv
verilog/imm_generator.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/idu_top.sv
testbench/idu_sva.sv
testbench/idu_tb.sv

/* testbench/idu_sva.sv */
// idu_sva
// free list occupancy assertions, bound into every free_list instance
`timescale 1ns/10ps
`default_nettype none

module idu_sva
	import idu_pkg::*;
#(
	parameter int PHYS_REG_NUM = 64,
	parameter int CNT_W        = 6
) (
	input logic             clk,
	input logic             reset,
	input logic             pop,
	input logic             push,
	input logic [CNT_W-1:0] count,
	input logic             can_rename
);

	// free registers beyond the architectural set
	localparam int FREE_NUM = PHYS_REG_NUM - ARCH_REG_NUM;

	// a push when full would take the count above capacity
	push_not_full: assert property (@(posedge clk) disable iff (reset)
		push |-> count != CNT_W'(FREE_NUM))
		else $error("push into a full free list");

	// pop on empty would take the count below zero
	pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		pop |-> count != '0)
		else $error("pop from an empty free list");

	// a returned register is available for renaming on the next cycle
	restore_after_push: assert property (@(posedge clk) disable iff (reset)
		push && !pop |=> can_rename)
		else $error("can_rename still low after a push into the free list");

endmodule

bind free_list idu_sva #(
	.PHYS_REG_NUM (PHYS_REG_NUM),
	.CNT_W        (CNT_W)
) i_idu_sva (
	.clk        (clk),
	.reset      (reset),
	.pop        (pop),
	.push       (push),
	.count      (count),
	.can_rename (can_rename)
);

`default_nettype wire

/* testbench/idu_tb.sv */
// idu_tb
// random-stimulus testbench for the decode-rename stage against a reference model
`timescale 1ns/10ps
`default_nettype none

module idu_tb
	import idu_pkg::*;
();

	logic                  clk;
	logic                  reset;
	logic [XLEN-1:0]       instruction;
	logic [31:0]           pc_in;
	logic                  new_valid_in;
	logic                  flush;
	logic                  commit_valid;
	logic                  commit_with_write;
	logic [PHYS_REG_W-1:0] commited_wr_register;
	control_t              control;
	logic [31:0]           pc_out;
	logic [PHYS_REG_W-1:0] phy_read_reg_num1;
	logic [PHYS_REG_W-1:0] phy_read_reg_num2;
	logic [PHYS_REG_W-1:0] phy_write_reg_num;
	logic [XLEN-1:0]       generated_immediate;
	logic                  can_rename;
	logic                  new_valid_inst_out;

	// reference state: map table, free list, registers handed out
	logic [PHYS_REG_W-1:0] map_m [32];
	logic [PHYS_REG_W-1:0] free_q [$];
	logic [PHYS_REG_W-1:0] alloc_q [$];

	// prediction for the next output edge
	logic                  exp_valid;
	control_t              exp_ctrl;
	logic [XLEN-1:0]       exp_imm;
	logic [31:0]           exp_pc;
	logic [PHYS_REG_W-1:0] exp_rs1;
	logic [PHYS_REG_W-1:0] exp_rs2;
	logic [PHYS_REG_W-1:0] exp_rd;
	int                    wait_cnt;

	idu_top #(
		.INST_ADDR_WIDTH (32),
		.PHYS_REG_NUM    (64)
	) i_idu_top (
		.clk                  (clk),
		.reset                (reset),
		.instruction          (instruction),
		.pc_in                (pc_in),
		.new_valid_in         (new_valid_in),
		.flush                (flush),
		.commit_valid         (commit_valid),
		.commit_with_write    (commit_with_write),
		.commited_wr_register (commited_wr_register),
		.control              (control),
		.pc_out               (pc_out),
		.phy_read_reg_num1    (phy_read_reg_num1),
		.phy_read_reg_num2    (phy_read_reg_num2),
		.phy_write_reg_num    (phy_write_reg_num),
		.generated_immediate  (generated_immediate),
		.can_rename           (can_rename),
		.new_valid_inst_out   (new_valid_inst_out)
	);

	// 20 ns period
	always #10 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
			$display("Some tests failed");
			$fatal(1);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	// first five entries are the register-writing formats
	function automatic logic [31:0] random_inst(input bit writer_only);
		opcode_t     ops [8] = '{r_type, i_type, load_type, u_type, uj_type,
			s_type, sb_type, nop};
		logic [31:0] w;
		w = $urandom();
		w[6:0] = writer_only ? ops[$urandom_range(0, 4)] : ops[$urandom_range(0, 7)];
		if (writer_only && w[11:7] == 5'd0)
			w[11:7] = 5'd1;
		return w;
	endfunction

	function automatic logic is_writer(input logic [6:0] op);
		return op == r_type || op == i_type || op == load_type || op == u_type ||
			op == uj_type;
	endfunction

	// control word straight from the rv32i format rules
	function automatic control_t model_control(input logic [31:0] w);
		alu_op_t  f3_ops [8] = '{add_op, sll_op, slt_op, slt_op, xor_op, srl_op,
			or_op, and_op};
		control_t c;
		c = ctrl_nop;
		case (w[6:0])
			r_type, i_type: begin
				c.alu_src = (w[6:0] == r_type) ? src_reg2 : src_imm;
				c.alu_op  = f3_ops[w[14:12]];
				// func7[5]: sra and srai, sub only for register ops
				if (w[30] && w[14:12] == 3'b101)
					c.alu_op = sra_op;
				if (w[30] && w[14:12] == 3'b000 && w[6:0] == r_type)
					c.alu_op = sub_op;
				c.reg_wb = 1'b1;
			end
			load_type: begin
				c.alu_src   = src_imm;
				c.memory_op = load_op;
				c.reg_wb    = 1'b1;
			end
			s_type: begin
				c.alu_src   = src_imm;
				c.memory_op = store_op;
			end
			sb_type: begin
				c.alu_op       = sub_op;
				c.is_branch_op = 1'b1;
			end
			u_type, uj_type: begin
				c.alu_src = src_imm;
				c.alu_op  = pass_b_op;
				c.reg_wb  = 1'b1;
			end
			default: c = ctrl_nop;
		endcase
		return c;
	endfunction

	function automatic logic [31:0] model_imm(input logic [31:0] w);
		logic [12:0] b;
		logic [20:0] j;
		b = {w[31], w[7], w[30:25], w[11:8], 1'b0};
		j = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		case (w[6:0])
			i_type, load_type: return 32'($signed(w[31:20]));
			s_type:            return 32'($signed({w[31:25], w[11:7]}));
			sb_type:           return 32'($signed(b));
			u_type:            return {w[31:12], 12'h000};
			uj_type:           return 32'($signed(j));
			default:           return 32'h0;
		endcase
	endfunction

	task automatic compare_outputs();
		check_value("valid_out", exp_valid, new_valid_inst_out);
		check_value("control", exp_ctrl, control);
		check_value("immediate", exp_imm, generated_immediate);
		check_value("pc_out", exp_pc, pc_out);
		check_value("phy_rs1", exp_rs1, phy_read_reg_num1);
		check_value("phy_rs2", exp_rs2, phy_read_reg_num2);
		check_value("phy_rd", exp_rd, phy_write_reg_num);
	endtask

	// one cycle: check last prediction, drive on the falling edge, predict
	task automatic step(input logic [31:0] inst, input logic valid, input logic fl,
		input logic cmt);
		logic acc;
		@(negedge clk);
		compare_outputs();
		check_value("can_rename", free_q.size() != 0, can_rename);
		instruction  = inst;
		pc_in        = $urandom();
		new_valid_in = valid;
		flush        = fl;
		// commits return only registers that were handed out
		if (cmt && alloc_q.size() != 0) begin
			commit_valid         = 1'b1;
			commit_with_write    = 1'b1;
			commited_wr_register = alloc_q.pop_front();
		end else begin
			commit_valid         = $urandom_range(0, 1);
			commit_with_write    = commit_valid ? 1'b0 : 1'($urandom_range(0, 1));
			commited_wr_register = $urandom();
		end
		acc       = valid && !fl && free_q.size() != 0;
		exp_valid = acc;
		exp_ctrl  = acc ? model_control(inst) : ctrl_nop;
		exp_imm   = model_imm(inst);
		exp_pc    = pc_in;
		// sources see the map before this update
		exp_rs1   = map_m[inst[19:15]];
		exp_rs2   = map_m[inst[24:20]];
		if (acc && is_writer(inst[6:0]) && inst[11:7] != 5'd0) begin
			exp_rd = free_q.pop_front();
			map_m[inst[11:7]] = exp_rd;
			alloc_q.push_back(exp_rd);
		end else begin
			exp_rd = map_m[inst[11:7]];
		end
		if (commit_valid && commit_with_write)
			free_q.push_back(commited_wr_register);
	endtask

	initial begin
		void'($urandom(32'hbca5a8b3));
		clk                  = 1'b0;
		reset                = 1'b1;
		instruction          = '0;
		pc_in                = '0;
		new_valid_in         = 1'b0;
		flush                = 1'b0;
		commit_valid         = 1'b0;
		commit_with_write    = 1'b0;
		commited_wr_register = '0;
		// identity map, free list 32..63 in order
		for (int i = 0; i < 32; i++) begin
			map_m[i] = PHYS_REG_W'(i);
			free_q.push_back(PHYS_REG_W'(32 + i));
		end
		// outputs after reset with zero inputs
		exp_valid = 1'b0;
		exp_ctrl  = ctrl_nop;
		exp_imm   = '0;
		exp_pc    = '0;
		exp_rs1   = '0;
		exp_rs2   = '0;
		exp_rd    = '0;
		repeat (2) @(negedge clk);
		// stage registers still held in reset
		compare_outputs();
		reset = 1'b0;

		// no commits, drain the list with bubbles and flushes mixed in
		wait_cnt = 0;
		while (can_rename) begin
			if (wait_cnt >= 1000)
				fail_timeout("free list to drain");
			step(random_inst(0), $urandom_range(0, 3) != 0, $urandom_range(0, 7) == 0, 1'b0);
			wait_cnt++;
		end

		// stalled, valid inputs must be dropped
		repeat (4) step(random_inst(1), 1'b1, 1'b0, 1'b0);

		// one commit restores can_rename and is the next register handed out
		step(random_inst(1), 1'b0, 1'b0, 1'b1);
		wait_cnt = 0;
		while (!can_rename) begin
			if (wait_cnt >= 10)
				fail_timeout("can_rename after commit");
			step(random_inst(1), 1'b0, 1'b0, 1'b0);
			wait_cnt++;
		end
		step(random_inst(1), 1'b1, 1'b0, 1'b0);

		// random mix of renames, bubbles, flushes and commits
		repeat (3000) begin
			step(random_inst(0), $urandom_range(0, 3) != 0, $urandom_range(0, 9) == 0,
				$urandom_range(0, 2) == 0);
		end
		// flush out the last prediction
		step(32'h0, 1'b0, 1'b0, 1'b0);

		$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/control_unit.sv */
// control_unit
// combinational decode of opcode, func3 and func7 into the control word
`timescale 1ns/10ps
`default_nettype none

module control_unit
	import idu_pkg::*;
(
	input  opcode_t      opcode,
	input  logic [2:0]   func3,
	input  logic [6:0]   func7,
	output control_t     control
);

	// alu op from func3
	// alt is func7[5], sub only allowed for register-register
	function automatic alu_op_t alu_from_func(
		input logic [2:0] f3,
		input logic       alt,
		input logic       allow_sub
	);
		alu_op_t op;
		case (f3)
			3'b000: op = (allow_sub && alt) ? sub_op : add_op;
			3'b001: op = sll_op;
			// slt and sltu share one op
			3'b010: op = slt_op;
			3'b011: op = slt_op;
			3'b100: op = xor_op;
			// srl / sra, srli / srai
			3'b101: op = alt ? sra_op : srl_op;
			3'b110: op = or_op;
			default: op = and_op;
		endcase
		return op;
	endfunction

	always_comb begin
		// unknown opcodes fall through as a bubble
		control = ctrl_nop;
		case (opcode)
			r_type: begin
				control.alu_src = src_reg2;
				control.alu_op  = alu_from_func(func3, func7[5], 1'b1);
				control.reg_wb  = 1'b1;
			end
			i_type: begin
				control.alu_src = src_imm;
				control.alu_op  = alu_from_func(func3, func7[5], 1'b0);
				control.reg_wb  = 1'b1;
			end
			load_type: begin
				// address = rs1 + imm
				control.alu_src   = src_imm;
				control.alu_op    = add_op;
				control.memory_op = load_op;
				control.reg_wb    = 1'b1;
			end
			s_type: begin
				control.alu_src   = src_imm;
				control.alu_op    = add_op;
				control.memory_op = store_op;
			end
			sb_type: begin
				// compare by subtraction
				control.alu_src      = src_reg2;
				control.alu_op       = sub_op;
				control.is_branch_op = 1'b1;
			end
			u_type, uj_type: begin
				control.alu_src = src_imm;
				control.alu_op  = pass_b_op;
				control.reg_wb  = 1'b1;
			end
			default: control = ctrl_nop;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/free_list.sv */
// free_list
// circular queue of free physical registers, filled with ARCH_REG_NUM and up at reset
`timescale 1ns/10ps
`default_nettype none

module free_list
	import idu_pkg::*;
#(
	parameter int PHYS_REG_NUM = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  pop,
	input  logic                  push,
	input  logic [PHYS_REG_W-1:0] push_reg,
	output logic [PHYS_REG_W-1:0] free_head,
	output logic                  can_rename
);

	// registers beyond the architectural set
	localparam int FREE_NUM = PHYS_REG_NUM - ARCH_REG_NUM;
	localparam int PTR_W    = $clog2(FREE_NUM);
	localparam int CNT_W    = $clog2(FREE_NUM + 1);

	logic [PHYS_REG_W-1:0] queue [FREE_NUM];
	logic [PTR_W-1:0]      head_ptr;
	logic [PTR_W-1:0]      tail_ptr;
	logic [CNT_W-1:0]      count;
	logic                  do_pop;
	logic                  do_push;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(FREE_NUM - 1)) ? '0 : p + 1'b1;
	endfunction

	// pop on empty and push on full are dropped
	assign do_pop     = pop && (count != '0);
	assign do_push    = push && (count != CNT_W'(FREE_NUM));
	assign free_head  = queue[head_ptr];
	assign can_rename = (count != '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// ascending fill, head at the first non-architectural register
			for (int i = 0; i < FREE_NUM; i++) begin
				queue[i] <= PHYS_REG_W'(ARCH_REG_NUM + i);
			end
			head_ptr <= '0;
			tail_ptr <= '0;
			count    <= CNT_W'(FREE_NUM);
		end else begin
			if (do_push) begin
				queue[tail_ptr] <= push_reg;
				tail_ptr        <= ptr_next(tail_ptr);
			end
			if (do_pop)
				head_ptr <= ptr_next(head_ptr);
			// pop and push together leave the count alone
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/idu_pkg.sv */
// idu_pkg
// widths, instruction encodings and control types for the decode-rename stage
`default_nettype none

package idu_pkg;

	// datapath and immediate width
	localparam int XLEN = 32;

	// register index widths
	localparam int ARCH_REG_W = 5;
	localparam int PHYS_REG_W = 6;

	// architectural register count, also the first free physical register
	localparam int ARCH_REG_NUM = 2 ** ARCH_REG_W;

	// major opcodes, instruction[6:0]
	typedef enum logic [6:0] {
		r_type    = 7'b0110011,
		i_type    = 7'b0010011,
		load_type = 7'b0000011,
		s_type    = 7'b0100011,
		sb_type   = 7'b1100011,
		u_type    = 7'b0110111,
		uj_type   = 7'b1101111,
		nop       = 7'b0000000
	} opcode_t;

	// alu operations seen by the backend
	typedef enum logic [3:0] {
		add_op,
		sub_op,
		and_op,
		or_op,
		xor_op,
		sll_op,
		srl_op,
		sra_op,
		slt_op,
		// operand b straight through, lui and jal
		pass_b_op
	} alu_op_t;

	typedef enum logic [1:0] {
		no_mem_op,
		load_op,
		store_op
	} mem_op_t;

	// second alu operand select
	typedef enum logic {
		src_reg2,
		src_imm
	} alu_src_t;

	// 9 bits in all
	typedef struct packed {
		alu_src_t alu_src;
		alu_op_t  alu_op;
		logic     is_branch_op;
		mem_op_t  memory_op;
		logic     reg_wb;
	} control_t;

	// bubble and reset value
	localparam control_t ctrl_nop = '{
		alu_src:      src_reg2,
		alu_op:       add_op,
		is_branch_op: 1'b0,
		memory_op:    no_mem_op,
		reg_wb:       1'b0
	};

endpackage

`default_nettype wire

/* verilog/idu_top.sv */
// idu_top
// single-issue decode and rename stage, all outputs registered one cycle after input
`timescale 1ns/10ps
`default_nettype none

module idu_top
	import idu_pkg::*;
#(
	parameter int INST_ADDR_WIDTH = 32,
	parameter int PHYS_REG_NUM    = 2 ** PHYS_REG_W
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic [XLEN-1:0]            instruction,
	input  logic [INST_ADDR_WIDTH-1:0] pc_in,
	input  logic                       new_valid_in,
	input  logic                       flush,
	input  logic                       commit_valid,
	input  logic                       commit_with_write,
	input  logic [PHYS_REG_W-1:0]      commited_wr_register,
	output control_t                   control,
	output logic [INST_ADDR_WIDTH-1:0] pc_out,
	output logic [PHYS_REG_W-1:0]      phy_read_reg_num1,
	output logic [PHYS_REG_W-1:0]      phy_read_reg_num2,
	output logic [PHYS_REG_W-1:0]      phy_write_reg_num,
	output logic [XLEN-1:0]            generated_immediate,
	output logic                       can_rename,
	output logic                       new_valid_inst_out
);

	opcode_t               opcode;
	control_t              control_d;
	logic [XLEN-1:0]       imm_d;
	logic [PHYS_REG_W-1:0] phy_rs1_d;
	logic [PHYS_REG_W-1:0] phy_rs2_d;
	logic [PHYS_REG_W-1:0] phy_rd_d;
	logic                  accept;
	logic                  writes_dest;
	logic                  rename;

	// nothing consumed while stalled or flushed
	assign accept = new_valid_in && !flush && can_rename;

	// bubble when not accepted
	assign opcode = accept ? opcode_t'(instruction[6:0]) : nop;

	// x0 writes are not renamed
	assign writes_dest = (opcode inside {r_type, i_type, load_type, u_type, uj_type}) &&
		(instruction[11:7] != '0);
	assign rename = accept && writes_dest;

	control_unit i_control_unit (
		.opcode  (opcode),
		.func3   (instruction[14:12]),
		.func7   (instruction[31:25]),
		.control (control_d)
	);

	imm_generator i_imm_generator (
		.instruction         (instruction),
		.generated_immediate (imm_d)
	);

	// commit with write returns the old register at the tail
	rename_map #(
		.PHYS_REG_NUM (PHYS_REG_NUM)
	) i_rename_map (
		.clk        (clk),
		.reset      (reset),
		.rs1        (instruction[19:15]),
		.rs2        (instruction[24:20]),
		.rd         (instruction[11:7]),
		.rename     (rename),
		.phy_rs1    (phy_rs1_d),
		.phy_rs2    (phy_rs2_d),
		.phy_rd     (phy_rd_d),
		.pop        (),
		.push       (commit_valid && commit_with_write),
		.push_reg   (commited_wr_register),
		.can_rename (can_rename)
	);

	// stage registers
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			control             <= ctrl_nop;
			pc_out              <= '0;
			phy_read_reg_num1   <= '0;
			phy_read_reg_num2   <= '0;
			phy_write_reg_num   <= '0;
			generated_immediate <= '0;
			new_valid_inst_out  <= 1'b0;
		end else begin
			control             <= control_d;
			pc_out              <= pc_in;
			phy_read_reg_num1   <= phy_rs1_d;
			phy_read_reg_num2   <= phy_rs2_d;
			phy_write_reg_num   <= phy_rd_d;
			generated_immediate <= imm_d;
			new_valid_inst_out  <= accept;
		end
	end

endmodule

`default_nettype wire

/* verilog/imm_generator.sv */
// imm_generator
// sign-extended immediate for the I, S, B, U and J formats
`timescale 1ns/10ps
`default_nettype none

module imm_generator
	import idu_pkg::*;
(
	input  logic [XLEN-1:0] instruction,
	output logic [XLEN-1:0] generated_immediate
);

	opcode_t opcode;

	assign opcode = opcode_t'(instruction[6:0]);

	always_comb begin
		case (opcode)
			// I format, addi and loads
			i_type, load_type:
				generated_immediate = {{(XLEN-12){instruction[31]}}, instruction[31:20]};
			// S format, split across rd field
			s_type:
				generated_immediate = {{(XLEN-12){instruction[31]}},
					instruction[31:25], instruction[11:7]};
			// B format, bit 0 always zero
			sb_type:
				generated_immediate = {{(XLEN-13){instruction[31]}}, instruction[31],
					instruction[7], instruction[30:25], instruction[11:8], 1'b0};
			// upper 20 bits
			u_type:
				generated_immediate = {instruction[31:12], 12'b0};
			// J format
			uj_type:
				generated_immediate = {{(XLEN-21){instruction[31]}}, instruction[31],
					instruction[19:12], instruction[20], instruction[30:21], 1'b0};
			// r_type and unknown codes carry no immediate
			default:
				generated_immediate = '0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/rename_map.sv */
// rename_map
// architectural to physical map table, allocates destinations from the free list
`timescale 1ns/10ps
`default_nettype none

module rename_map
	import idu_pkg::*;
#(
	parameter int PHYS_REG_NUM = 64
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [ARCH_REG_W-1:0] rs1,
	input  logic [ARCH_REG_W-1:0] rs2,
	input  logic [ARCH_REG_W-1:0] rd,
	input  logic                  rename,
	output logic [PHYS_REG_W-1:0] phy_rs1,
	output logic [PHYS_REG_W-1:0] phy_rs2,
	output logic [PHYS_REG_W-1:0] phy_rd,
	output logic                  pop,
	input  logic                  push,
	input  logic [PHYS_REG_W-1:0] push_reg,
	output logic                  can_rename
);

	logic [PHYS_REG_W-1:0] map_table [ARCH_REG_NUM];
	logic [PHYS_REG_W-1:0] free_head;

	// one allocation per renamed instruction
	assign pop = rename;

	free_list #(
		.PHYS_REG_NUM (PHYS_REG_NUM)
	) i_free_list (
		.clk        (clk),
		.reset      (reset),
		.pop        (pop),
		.push       (push),
		.push_reg   (push_reg),
		.free_head  (free_head),
		.can_rename (can_rename)
	);

	// sources read before this cycle's update
	// so rs == rd still sees the old mapping
	assign phy_rs1 = map_table[rs1];
	assign phy_rs2 = map_table[rs2];

	// new register on rename, else the current mapping
	assign phy_rd = rename ? free_head : map_table[rd];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			// identity map, x0 stays on p0
			for (int i = 0; i < ARCH_REG_NUM; i++) begin
				map_table[i] <= PHYS_REG_W'(i);
			end
		end else if (rename) begin
			map_table[rd] <= free_head;
		end
	end

endmodule

`default_nettype wire
